//--- all.f
+incdir+tb
common/csr_defs_pkg.sv
common/fpu_csr_pkg.sv
csr_file/fcsr_write_decode.sv
csr_file/warp_fcsr.sv
csr_file/csr_read_mux.sv
logic/csr_unit.sv
tb/csr_unit_tb.sv

//--- Makefile
VERILATOR  = verilator
FILELIST   = all.f
TB_TOP     = csr_unit_tb
RTL_TOP    = csr_unit
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/csr_unit_vectors.svh
/*
 * Stimulus table for csr_unit_tb, included inside the testbench module.
 * add_row columns: write, report 0, report 1, read, fpu_frm_wid 0 and 1,
 * then expected read_data_ro, read_data_rw, fpu_frm 0 and fpu_frm 1.
 * Each row reads the state left by the rows before it.
 */
task automatic build_vectors();
    csr_data_t d0, d1, d2, d3, d4;

    d0 = $random(seed);
    d1 = $random(seed);
    d2 = $random(seed);
    d3 = $random(seed);
    d4 = $random(seed);

    // All warps clear after reset
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_FFLAGS), 0, 1, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_FRM), 2, 3, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(2, CSR_FCSR), 1, 0, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(3, CSR_FCSR), 3, 2, 0, 0, 0, 0);

    // CSR writes, masked to the field width
    add_row(wr_req(1, CSR_FRM, d0), NO_REP, NO_REP, rd_req(1, CSR_FRM), 1, 0, 0, 0, 0, 0);
    add_row(wr_req(2, CSR_FFLAGS, d1), NO_REP, NO_REP, rd_req(1, CSR_FRM), 1, 0,
            0, d0 & 32'h7, d0 & 32'h7, 0);
    add_row(wr_req(3, CSR_FCSR, d2), NO_REP, NO_REP, rd_req(2, CSR_FFLAGS), 0, 2,
            0, d1 & 32'h1f, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(3, CSR_FCSR), 3, 1,
            0, d2 & 32'hff, (d2 >> 5) & 32'h7, d0 & 32'h7);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_FCSR), 0, 2, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_FFLAGS), 2, 3, 0, 0, 0, (d2 >> 5) & 32'h7);

    // Sticky flag reports from both blocks
    add_row(NO_WR, flag_rep(0, 5'h01), flag_rep(0, 5'h04), rd_req(0, CSR_FFLAGS), 2, 2,
            0, 0, 0, 0);
    add_row(NO_WR, flag_rep(0, 5'h10), flag_rep(1, 5'h02), rd_req(0, CSR_FFLAGS), 2, 2,
            0, 32'h05, 0, 0);
    add_row(NO_WR, flag_rep(1, 5'h02), flag_rep(2, 5'h08), rd_req(0, CSR_FFLAGS), 2, 2,
            0, 32'h15, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_FFLAGS), 2, 2, 0, 32'h02, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(2, CSR_FFLAGS), 2, 2, 0, (d1 & 32'h1f) | 32'h08, 0, 0);

    // Write and report in the same cycle
    add_row(wr_req(0, CSR_FFLAGS, d3), flag_rep(0, fflags_t'(~d3)), NO_REP,
            rd_req(0, CSR_FFLAGS), 2, 2, 0, 32'h15, 0, 0);
    add_row(wr_req(1, CSR_FRM, d4), NO_REP, flag_rep(1, 5'h10), rd_req(0, CSR_FFLAGS),
            2, 2, 0, d3 & 32'h1f, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_FCSR), 1, 0,
            0, ((d4 & 32'h7) << 5) | 32'h12, d4 & 32'h7, 0);

    // Write to a zero-valued machine CSR is dropped
    add_row(wr_req(1, CSR_MSTATUS, d2), NO_REP, NO_REP, rd_req(3, CSR_FFLAGS), 2, 2,
            0, d2 & 32'h1f, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_FCSR), 1, 3,
            0, ((d4 & 32'h7) << 5) | 32'h12, d4 & 32'h7, (d2 >> 5) & 32'h7);

    // Read-only CSRs
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_MVENDORID), 2, 2, VENDOR_ID, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_MARCHID), 2, 2, ARCH_ID, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_MISA), 2, 2, MISA_EXP, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(2, CSR_WARP_ID), 2, 2, 32'd2, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(2, CSR_THREAD_MASK), 2, 2, 32'(TMASKS[2]), 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_CORE_ID), 2, 2, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_WARP_MASK), 2, 2, 32'(ACTIVE), 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(3, CSR_NUM_THREADS), 2, 2, 32'd4, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(3, CSR_NUM_WARPS), 2, 2, 32'd4, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(3, CSR_NUM_CORES), 2, 2, 32'd1, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_MCYCLE), 2, 2, CYCLES[31:0], 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_MCYCLE_H), 2, 2, 32'(CYCLES >> 32), 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_MINSTRET), 2, 2, INSTRET[31:0], 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_MINSTRET_H), 2, 2, 32'(INSTRET >> 32), 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_SATP), 2, 2, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, CSR_MSTATUS), 2, 2, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, 12'hb05), 2, 2, 0, 0, 0, 0);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(1, 12'hb9f), 2, 2, 0, 0, 0, 0);

    // Rounding mode per FPU block, two warps at once
    add_row(wr_req(0, CSR_FCSR, d1), NO_REP, NO_REP, rd_req(0, CSR_FRM), 0, 3,
            0, 0, 0, (d2 >> 5) & 32'h7);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(0, CSR_FCSR), 0, 3,
            0, d1 & 32'hff, (d1 >> 5) & 32'h7, (d2 >> 5) & 32'h7);
    add_row(NO_WR, NO_REP, NO_REP, rd_req(2, CSR_FFLAGS), 3, 0,
            0, (d1 & 32'h1f) | 32'h08, (d2 >> 5) & 32'h7, (d1 >> 5) & 32'h7);
endtask

//--- tb/csr_unit_tb.sv
/*
 * Testbench for csr_unit, driven by the table in csr_unit_vectors.svh.
 * One row per clock. Inputs change on the rising edge and outputs are checked
 * just before the next one, so a row sees the writes of the rows before it.
 */
`timescale 1ns/1ps

module csr_unit_tb
    import csr_defs_pkg::*;
    import fpu_csr_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int CHECK_OFFSET = CLK_PERIOD - 5;
    localparam int RESET_CYCLES = 8;

    // Counter and mask inputs, the same on every row
    localparam perf_ctr_t                    CYCLES  = 44'h0ab_c123_4567;
    localparam perf_ctr_t                    INSTRET = 44'h3f0_0fed_cba9;
    localparam warp_mask_t                   ACTIVE  = 4'b1011;
    localparam thread_mask_t [NUM_WARPS-1:0] TMASKS  = 16'h83f1;
    // MXL of 1 with the I, M and F extension bits
    localparam csr_data_t MISA_EXP =
        (32'd1 << 30) | (32'd1 << 12) | (32'd1 << 8) | (32'd1 << 5);

    localparam csr_write_req_t   NO_WR  = '0;
    localparam fpu_flag_report_t NO_REP = '0;

    typedef struct packed {
        csr_write_req_t                        wr;
        fpu_flag_report_t [NUM_FPU_BLOCKS-1:0] flags;
        csr_read_req_t                         rd;
        wid_t             [NUM_FPU_BLOCKS-1:0] frm_wid;
        perf_ctr_t                             cycles;
        perf_ctr_t                             instret;
        warp_mask_t                            active;
        thread_mask_t     [NUM_WARPS-1:0]      tmasks;
        csr_data_t                             exp_ro;
        csr_data_t                             exp_rw;
        frm_t             [NUM_FPU_BLOCKS-1:0] exp_frm;
    } vector_t;

    logic                                  clk;
    logic                                  reset;
    csr_read_req_t                         csr_read;
    csr_write_req_t                        csr_write;
    fpu_flag_report_t [NUM_FPU_BLOCKS-1:0] fpu_flags;
    wid_t             [NUM_FPU_BLOCKS-1:0] fpu_frm_wid;
    perf_ctr_t                             cycles;
    perf_ctr_t                             instret;
    warp_mask_t                            active_warps;
    thread_mask_t     [NUM_WARPS-1:0]      thread_masks;
    csr_data_t                             read_data_ro;
    csr_data_t                             read_data_rw;
    frm_t             [NUM_FPU_BLOCKS-1:0] fpu_frm;

    vector_t vectors[$];
    integer  seed        = 32'h105d_11cd;
    logic    table_ready = 1'b0;
    int      checks      = 0;
    int      errors      = 0;

    csr_unit u_csr_unit (
        .clk          (clk),
        .reset        (reset),
        .csr_read     (csr_read),
        .csr_write    (csr_write),
        .fpu_flags    (fpu_flags),
        .fpu_frm_wid  (fpu_frm_wid),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .fpu_frm      (fpu_frm)
    );

    function automatic csr_write_req_t wr_req(int wid, csr_addr_t addr, csr_data_t data);
        return '{enable: 1'b1, wid: wid_t'(wid), addr: addr, data: data};
    endfunction

    function automatic csr_read_req_t rd_req(int wid, csr_addr_t addr);
        return '{enable: 1'b1, wid: wid_t'(wid), addr: addr};
    endfunction

    function automatic fpu_flag_report_t flag_rep(int wid, fflags_t flags);
        return '{valid: 1'b1, wid: wid_t'(wid), fflags: flags};
    endfunction

    function automatic void add_row(csr_write_req_t wr, fpu_flag_report_t f0,
                                    fpu_flag_report_t f1, csr_read_req_t rd,
                                    int fw0, int fw1, csr_data_t exp_ro,
                                    csr_data_t exp_rw, csr_data_t ef0, csr_data_t ef1);
        vector_t v;
        v = '{wr, {f1, f0}, rd, {wid_t'(fw1), wid_t'(fw0)}, CYCLES, INSTRET, ACTIVE,
              TMASKS, exp_ro, exp_rw, {frm_t'(ef1), frm_t'(ef0)}};
        vectors.push_back(v);
    endfunction

    `include "csr_unit_vectors.svh"

    task automatic drive_row(vector_t v);
        csr_write    <= v.wr;
        fpu_flags    <= v.flags;
        csr_read     <= v.rd;
        fpu_frm_wid  <= v.frm_wid;
        cycles       <= v.cycles;
        instret      <= v.instret;
        active_warps <= v.active;
        thread_masks <= v.tmasks;
    endtask

    task automatic check_row(int row, vector_t v);
        checks += 2 + NUM_FPU_BLOCKS;
        if (read_data_ro !== v.exp_ro) begin
            errors++;
            $display("ERR %0t: row %0d read_data_ro 0x%08h, expected 0x%08h",
                     $time, row, read_data_ro, v.exp_ro);
        end
        if (read_data_rw !== v.exp_rw) begin
            errors++;
            $display("ERR %0t: row %0d read_data_rw 0x%08h, expected 0x%08h",
                     $time, row, read_data_rw, v.exp_rw);
        end
        for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
            if (fpu_frm[b] !== v.exp_frm[b]) begin
                errors++;
                $display("ERR %0t: row %0d fpu_frm[%0d] %0d, expected %0d",
                         $time, row, b, fpu_frm[b], v.exp_frm[b]);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #((vectors.size() + RESET_CYCLES) * CLK_PERIOD * 2);
        $display("Timeout: the run did not end within %0d clock cycles",
                 (vectors.size() + RESET_CYCLES) * 2);
        $display("Test failures found");
        $finish;
    end

    initial begin
        build_vectors();
        table_ready = 1'b1;
        reset        <= 1'b1;
        csr_read     <= '0;
        csr_write    <= '0;
        fpu_flags    <= '0;
        fpu_frm_wid  <= '0;
        cycles       <= '0;
        instret      <= '0;
        active_warps <= '0;
        thread_masks <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            drive_row(vectors[i]);
            #(CHECK_OFFSET);
            check_row(i, vectors[i]);
        end
        $display("%0d rows, %0d checks, %0d errors", vectors.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- logic/csr_unit.sv
/*
 * CSR unit of one core: write decoder, per-warp FP status slices, read mux.
 * Single-cycle strobes, no back-pressure. Reads are combinational; writes
 * and flag reports show on the read ports one cycle later.
 */
`timescale 1ns/1ps

module csr_unit
    import csr_defs_pkg::*;
    import fpu_csr_pkg::*;
#(
    parameter int CORE_ID = 0
) (
    input  logic                                   clk,
    input  logic                                   reset,

    input  csr_read_req_t                          csr_read,
    input  csr_write_req_t                         csr_write,
    input  fpu_flag_report_t [NUM_FPU_BLOCKS-1:0]  fpu_flags,
    input  wid_t             [NUM_FPU_BLOCKS-1:0]  fpu_frm_wid,

    input  perf_ctr_t                              cycles,
    input  perf_ctr_t                              instret,
    input  warp_mask_t                             active_warps,
    input  thread_mask_t     [NUM_WARPS-1:0]       thread_masks,

    output csr_data_t                              read_data_ro,
    output csr_data_t                              read_data_rw,
    output frm_t             [NUM_FPU_BLOCKS-1:0]  fpu_frm
);

    fcsr_update_t [NUM_WARPS-1:0] updates;
    fcsr_t        [NUM_WARPS-1:0] fcsr_all;

    fcsr_write_decode u_write_decode (
        .csr_write (csr_write),
        .fpu_flags (fpu_flags),
        .updates   (updates)
    );

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        warp_fcsr u_warp_fcsr (
            .clk    (clk),
            .reset  (reset),
            .update (updates[w]),
            .fcsr   (fcsr_all[w])
        );
    end

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) u_read_mux (
        .csr_read     (csr_read),
        .fcsr_all     (fcsr_all),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .fpu_frm_wid  (fpu_frm_wid),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .fpu_frm      (fpu_frm)
    );

endmodule

//--- csr_file/csr_read_mux.sv
/*
 * Combinational CSR read path and per-block rounding-mode lookup.
 * Monitor-window addresses are legal and read zero; counter high halves
 * are zero-extended. Unknown addresses read zero and raise an error.
 */
`timescale 1ns/1ps

module csr_read_mux
    import csr_defs_pkg::*;
    import fpu_csr_pkg::*;
#(
    parameter int CORE_ID = 0
) (
    input  csr_read_req_t                       csr_read,
    input  fcsr_t         [NUM_WARPS-1:0]       fcsr_all,
    input  perf_ctr_t                           cycles,
    input  perf_ctr_t                           instret,
    input  warp_mask_t                          active_warps,
    input  thread_mask_t  [NUM_WARPS-1:0]       thread_masks,
    input  wid_t          [NUM_FPU_BLOCKS-1:0]  fpu_frm_wid,
    output csr_data_t                           read_data_ro,
    output csr_data_t                           read_data_rw,
    output frm_t          [NUM_FPU_BLOCKS-1:0]  fpu_frm
);

    fcsr_t rd_fcsr;
    logic  in_mpm_window;
    logic  read_addr_ok;

    assign rd_fcsr = fcsr_all[csr_read.wid];

    always_comb begin
        read_data_ro  = '0;
        read_data_rw  = '0;
        read_addr_ok  = 1'b1;
        in_mpm_window =
            (csr_read.addr[CSR_ADDR_BITS-1:MPM_WINDOW_BITS]
                == CSR_MPM_BASE[CSR_ADDR_BITS-1:MPM_WINDOW_BITS])
            || (csr_read.addr[CSR_ADDR_BITS-1:MPM_WINDOW_BITS]
                == CSR_MPM_BASE_H[CSR_ADDR_BITS-1:MPM_WINDOW_BITS]);

        case (csr_read.addr)
            CSR_FFLAGS:      read_data_rw = 32'(rd_fcsr.fflags);
            CSR_FRM:         read_data_rw = 32'(rd_fcsr.frm);
            CSR_FCSR:        read_data_rw = 32'(rd_fcsr);

            CSR_MVENDORID:   read_data_ro = VENDOR_ID;
            CSR_MARCHID:     read_data_ro = ARCH_ID;
            CSR_MIMPID:      read_data_ro = IMPL_ID;
            CSR_MISA:        read_data_ro = MISA_VALUE;

            CSR_WARP_ID:     read_data_ro = 32'(csr_read.wid);
            CSR_CORE_ID:     read_data_ro = 32'(CORE_ID);
            CSR_THREAD_MASK: read_data_ro = 32'(thread_masks[csr_read.wid]);
            CSR_WARP_MASK:   read_data_ro = 32'(active_warps);
            CSR_NUM_THREADS: read_data_ro = 32'(NUM_THREADS);
            CSR_NUM_WARPS:   read_data_ro = 32'(NUM_WARPS);
            CSR_NUM_CORES:   read_data_ro = 32'(NUM_CORES_TOTAL);

            CSR_MCYCLE:      read_data_ro = cycles[31:0];
            CSR_MCYCLE_H:    read_data_ro = 32'(cycles[PERF_CTR_BITS-1:32]);
            CSR_MINSTRET:    read_data_ro = instret[31:0];
            CSR_MINSTRET_H:  read_data_ro = 32'(instret[PERF_CTR_BITS-1:32]);

            CSR_SATP, CSR_MSTATUS, CSR_MNSTATUS, CSR_MEDELEG, CSR_MIDELEG,
            CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0: ;

            // Rest of the monitor windows reads zero
            default:         read_addr_ok = in_mpm_window;
        endcase

        if (csr_read.enable) begin
            assert (read_addr_ok)
                else $error("%t: invalid CSR read address 0x%0h", $time, csr_read.addr);
        end
    end

    // Each FPU block picks its own warp, independent of the CSR read port
    always_comb begin
        for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
            fpu_frm[b] = fcsr_all[fpu_frm_wid[b]].frm;
        end
    end

endmodule

//--- csr_file/warp_fcsr.sv
/*
 * Floating-point status register of one warp.
 * Flags are sticky; a CSR write in the same cycle overrides the field it
 * addresses. Updates are visible one cycle after the edge that takes them.
 */
`timescale 1ns/1ps

module warp_fcsr
    import fpu_csr_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  fcsr_update_t update,
    output fcsr_t        fcsr
);

    fcsr_t fcsr_r;
    fcsr_t fcsr_n;

    always_comb begin
        fcsr_n        = fcsr_r;
        fcsr_n.fflags = fcsr_r.fflags | update.sticky_flags;
        case (update.kind)
            FFLAGS:  fcsr_n.fflags = update.value.fflags;
            // Reported flags survive a rounding-mode write
            FRM:     fcsr_n.frm = update.value.frm;
            FCSR:    fcsr_n = update.value;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_r <= '0;
        end else begin
            fcsr_r <= fcsr_n;
        end
    end

    assign fcsr = fcsr_r;

    a_kind_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(update.kind));

    // Flags never clear without a flag write
    a_flags_sticky: assert property (@(posedge clk) disable iff (reset)
        update.kind inside {NONE, FRM}
        |=> (fcsr.fflags & $past(fcsr.fflags)) == $past(fcsr.fflags));

endmodule

//--- csr_file/fcsr_write_decode.sv
/*
 * Merges the CSR write port and all FPU flag reports into one update per warp.
 * Purely combinational. Writes to the zero-valued machine CSRs are accepted
 * and dropped; any other write address is an error.
 */
`timescale 1ns/1ps

module fcsr_write_decode
    import csr_defs_pkg::*;
    import fpu_csr_pkg::*;
(
    input  csr_write_req_t                         csr_write,
    input  fpu_flag_report_t [NUM_FPU_BLOCKS-1:0]  fpu_flags,
    output fcsr_update_t     [NUM_WARPS-1:0]       updates
);

    fcsr_wr_kind_t write_kind;
    fcsr_t         write_value;
    logic          write_addr_ok;

    always_comb begin
        write_kind    = NONE;
        write_value   = '0;
        write_addr_ok = 1'b1;
        case (csr_write.addr)
            CSR_FFLAGS: begin
                write_kind         = FFLAGS;
                write_value.fflags = csr_write.data[FFLAGS_BITS-1:0];
            end
            CSR_FRM: begin
                write_kind      = FRM;
                write_value.frm = csr_write.data[FRM_BITS-1:0];
            end
            CSR_FCSR: begin
                write_kind  = FCSR;
                write_value = csr_write.data[FRM_BITS+FFLAGS_BITS-1:0];
            end
            CSR_SATP, CSR_MSTATUS, CSR_MNSTATUS, CSR_MEDELEG, CSR_MIDELEG,
            CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0: ;
            default: write_addr_ok = 1'b0;
        endcase

        if (csr_write.enable) begin
            assert (write_addr_ok)
                else $error("%t: invalid CSR write address 0x%0h", $time, csr_write.addr);
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            updates[w].sticky_flags = '0;
            // Several blocks may report to the same warp
            for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
                if (fpu_flags[b].valid && fpu_flags[b].wid == wid_t'(w)) begin
                    updates[w].sticky_flags = updates[w].sticky_flags | fpu_flags[b].fflags;
                end
            end
            if (csr_write.enable && csr_write.wid == wid_t'(w)) begin
                updates[w].kind = write_kind;
            end else begin
                updates[w].kind = NONE;
            end
            updates[w].value = write_value;
        end
    end

endmodule

//--- common/fpu_csr_pkg.sv
/*
 * Floating-point status types shared by the write decoder, the per-warp
 * slices and the read mux. fcsr_t packs frm above fflags, as in the FCSR CSR.
 */
package fpu_csr_pkg;

    import csr_defs_pkg::*;

    localparam int FFLAGS_BITS = 5;
    localparam int FRM_BITS    = 3;

    typedef logic [FFLAGS_BITS-1:0] fflags_t;
    typedef logic [FRM_BITS-1:0]    frm_t;

    typedef struct packed {
        frm_t    frm;
        fflags_t fflags;
    } fcsr_t;

    typedef struct packed {
        logic    valid;
        wid_t    wid;
        fflags_t fflags;
    } fpu_flag_report_t;

    typedef enum logic [1:0] {
        NONE   = 2'd0,
        FFLAGS = 2'd1,
        FRM    = 2'd2,
        FCSR   = 2'd3
    } fcsr_wr_kind_t;

    // value is already aligned to fcsr_t for every kind
    typedef struct packed {
        fflags_t       sticky_flags;
        fcsr_wr_kind_t kind;
        fcsr_t         value;
    } fcsr_update_t;

endpackage

//--- common/csr_defs_pkg.sv
/*
 * CSR addresses, core geometry and access request types for the CSR unit.
 * Geometry is fixed at 4 warps x 4 threads with 2 FPU blocks and 44-bit counters.
 * Both monitor windows are 32 entries long and aligned to 32.
 */
package csr_defs_pkg;

    localparam int NUM_WARPS       = 4;
    localparam int NUM_THREADS     = 4;
    localparam int NUM_FPU_BLOCKS  = 2;
    localparam int NUM_CORES_TOTAL = 1;
    localparam int PERF_CTR_BITS   = 44;

    localparam int CSR_ADDR_BITS   = 12;
    localparam int CSR_DATA_BITS   = 32;
    localparam int WID_BITS        = $clog2(NUM_WARPS);
    localparam int MPM_WINDOW      = 32;
    localparam int MPM_WINDOW_BITS = $clog2(MPM_WINDOW);

    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [CSR_DATA_BITS-1:0] csr_data_t;
    typedef logic [WID_BITS-1:0]      wid_t;
    typedef logic [NUM_WARPS-1:0]     warp_mask_t;
    typedef logic [NUM_THREADS-1:0]   thread_mask_t;
    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

    localparam csr_data_t VENDOR_ID  = 32'h0000_0000;
    localparam csr_data_t ARCH_ID    = 32'h0000_0001;
    localparam csr_data_t IMPL_ID    = 32'h0000_0001;
    // MXL=1 (XLEN 32), extensions I, M and F
    localparam csr_data_t MISA_VALUE = 32'h4000_1120;

    // Floating-point status
    localparam csr_addr_t CSR_FFLAGS      = 12'h001;
    localparam csr_addr_t CSR_FRM         = 12'h002;
    localparam csr_addr_t CSR_FCSR        = 12'h003;

    // Machine CSRs that always read zero
    localparam csr_addr_t CSR_SATP        = 12'h180;
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MISA        = 12'h301;
    localparam csr_addr_t CSR_MEDELEG     = 12'h302;
    localparam csr_addr_t CSR_MIDELEG     = 12'h303;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam csr_addr_t CSR_MTVEC       = 12'h305;
    localparam csr_addr_t CSR_MEPC        = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0     = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0    = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS    = 12'h744;

    // Counters, with the monitor windows wrapped around them
    localparam csr_addr_t CSR_MPM_BASE    = 12'hB00;
    localparam csr_addr_t CSR_MCYCLE      = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET    = 12'hB02;
    localparam csr_addr_t CSR_MPM_BASE_H  = 12'hB80;
    localparam csr_addr_t CSR_MCYCLE_H    = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET_H  = 12'hB82;

    localparam csr_addr_t CSR_WARP_ID     = 12'hCC1;
    localparam csr_addr_t CSR_CORE_ID     = 12'hCC2;
    localparam csr_addr_t CSR_WARP_MASK   = 12'hCC3;
    localparam csr_addr_t CSR_THREAD_MASK = 12'hCC4;
    localparam csr_addr_t CSR_MVENDORID   = 12'hF11;
    localparam csr_addr_t CSR_MARCHID     = 12'hF12;
    localparam csr_addr_t CSR_MIMPID      = 12'hF13;
    localparam csr_addr_t CSR_NUM_THREADS = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS   = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES   = 12'hFC2;

    typedef struct packed {
        logic      enable;
        wid_t      wid;
        csr_addr_t addr;
    } csr_read_req_t;

    typedef struct packed {
        logic      enable;
        wid_t      wid;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_req_t;

endpackage
